/* Makefile */
# Verilator build for the execute stage testbench
# a failing run ends in $fatal, so the run target fails with it

VERILATOR ?= verilator
TOP       ?= tb_ex_stage
FILELIST  ?= all.f
BUILD_DIR ?= obj_dir
JOBS      ?= 0
VFLAGS    ?= --binary --timing --assert -j $(JOBS)

SIM = $(BUILD_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: compile
	./$(SIM)

clean:
	rm -rf $(BUILD_DIR)

/* all.f */
ex_pkg.sv
ex_decode.sv
ex_alu.sv
ex_commit.sv
ex_lsq_credit.sv
ex_stage_top.sv
tb_clock_gen.sv
tb_ex_stage.sv

/* ex_alu.sv */
//--------------------------------------------------------------------------
// execute ALU and branch comparator
// both purely combinational on the registered stage
//--------------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module ex_alu import ex_pkg::*; (
    input  wire ex_stage_t  stage_i,
    output      ex_result_u result_o,
    output      logic       cmp_o
);

    logic [XLEN-1:0]    left;
    logic [XLEN-1:0]    right;
    logic [SHAMT_W-1:0] shamt;

    assign left  = stage_i.operand_left;
    assign right = stage_i.operand_right;
    assign shamt = right[SHAMT_W-1:0];

    //--------------------------------------------------------------------------
    // alu
    //--------------------------------------------------------------------------
    always_comb begin
        case (stage_i.alu_op)
            ALU_ADD:  result_o.data = left + right;
            ALU_SUB:  result_o.data = left - right;
            ALU_AND:  result_o.data = left & right;
            ALU_OR:   result_o.data = left | right;
            ALU_XOR:  result_o.data = left ^ right;
            ALU_SLL:  result_o.data = left << shamt;
            ALU_SRL:  result_o.data = left >> shamt;
            ALU_SRA:  result_o.data = $signed(left) >>> shamt;
            ALU_SLT:  result_o.data = {{(XLEN-1){1'b0}}, $signed(left) < $signed(right)};
            ALU_SLTU: result_o.data = {{(XLEN-1){1'b0}}, left < right};
            default:  result_o.data = '0;
        endcase
    end

    //--------------------------------------------------------------------------
    // branch comparator
    //--------------------------------------------------------------------------
    always_comb begin
        case (stage_i.funct3)
            F3_BEQ:  cmp_o = stage_i.cmp_left == stage_i.cmp_right;
            F3_BNE:  cmp_o = stage_i.cmp_left != stage_i.cmp_right;
            F3_BLT:  cmp_o = $signed(stage_i.cmp_left) < $signed(stage_i.cmp_right);
            F3_BGE:  cmp_o = $signed(stage_i.cmp_left) >= $signed(stage_i.cmp_right);
            F3_BLTU: cmp_o = stage_i.cmp_left < stage_i.cmp_right;
            F3_BGEU: cmp_o = stage_i.cmp_left >= stage_i.cmp_right;
            default: cmp_o = 1'b0;
        endcase
    end

    // decoder must never hand over an opcode outside the ten operations
    always_comb begin
        if (stage_i.valid) begin
            a_alu_op_known: assert (!$isunknown(stage_i.alu_op) && stage_i.alu_op inside
                {ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR,
                 ALU_SLL, ALU_SRL, ALU_SRA, ALU_SLT, ALU_SLTU})
                else $error("unknown alu_op on a valid stage");
        end
    end

endmodule

`default_nettype wire

/* ex_commit.sv */
//--------------------------------------------------------------------------
// execute commit logic
// qualifies the stage, flags misalignment, forms the outputs and stalls
// a load or store that finds no queue credit
//--------------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module ex_commit import ex_pkg::*; (
    input  wire ex_stage_t    stage_i,
    input  wire ex_result_u   result_i,
    input  wire logic         cmp_i,
    input  wire logic         has_credit_i,
    output      logic         take_o,
    output      logic         stall_o,
    output      ex_wb_t       wb_o,
    output      ex_lsq_t      lsq_o,
    output      ex_redirect_t redirect_o,
    output      ex_excp_t     excp_o
);

    logic cond_ok;
    logic misaligned;
    logic excp_maif;
    logic excp_mala;
    logic excp_masa;
    logic commit;
    logic lsq_req;

    //--------------------------------------------------------------------------
    // exception detection
    //--------------------------------------------------------------------------
    assign excp_maif = stage_i.jump & (result_i.addr.offset != 2'b00);

    always_comb begin
        case (stage_i.funct3)
            F3_BYTE: misaligned = 1'b0;
            F3_HALF: misaligned = result_i.addr.offset[0];
            F3_WORD: misaligned = result_i.addr.offset != 2'b00;
            default: misaligned = 1'b0;
        endcase
    end

    assign excp_mala = stage_i.lq_wr & misaligned;
    assign excp_masa = stage_i.sq_wr & misaligned;

    //--------------------------------------------------------------------------
    // qualification and stall
    //--------------------------------------------------------------------------
    // false compare retires silently
    assign cond_ok = ~stage_i.cond | cmp_i;
    assign commit  = stage_i.valid & cond_ok & ~(excp_maif | excp_mala | excp_masa);
    assign lsq_req = commit & (stage_i.lq_wr | stage_i.sq_wr);
    assign take_o  = lsq_req & has_credit_i;
    assign stall_o = lsq_req & ~has_credit_i;

    //--------------------------------------------------------------------------
    // outputs
    //--------------------------------------------------------------------------
    assign wb_o.wr   = commit & stage_i.regd_wr;
    assign wb_o.addr = stage_i.regd_addr;
    // link value replaces the alu result
    assign wb_o.data = stage_i.link ? stage_i.pc_inc : result_i.data;

    assign lsq_o.lq_wr     = take_o & stage_i.lq_wr;
    assign lsq_o.sq_wr     = take_o & stage_i.sq_wr;
    assign lsq_o.funct3    = stage_i.funct3;
    assign lsq_o.regd_addr = stage_i.regd_addr;
    assign lsq_o.data      = stage_i.regs2_data;
    assign lsq_o.addr      = result_i.addr;

    assign redirect_o.jump = commit & stage_i.jump;
    assign redirect_o.addr = result_i.addr;

    always_comb begin
        excp_o.pc    = stage_i.pc;
        excp_o.cause = EXCP_NONE;
        if (stage_i.valid && cond_ok) begin
            if (excp_maif) begin
                excp_o.cause = EXCP_MAIF;
            end else if (excp_mala) begin
                excp_o.cause = EXCP_MALA;
            end else if (excp_masa) begin
                excp_o.cause = EXCP_MASA;
            end
        end
    end

    // a queue take always pairs with a strobe, a credit and no stall
    always_comb begin
        if (take_o) begin
            a_take_credit: assert (has_credit_i && !stall_o && (lsq_o.lq_wr ^ lsq_o.sq_wr))
                else $error("queue take without credit");
        end
    end

endmodule

`default_nettype wire

/* ex_decode.sv */
//--------------------------------------------------------------------------
// execute issue register
// registers the decoded instruction, splits the zone into write flags
// and precomputes the link address
//--------------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module ex_decode import ex_pkg::*; (
    input  wire logic      clk_i,
    input  wire logic      resetb_i,
    input  wire logic      issue_valid_i,
    input  wire ex_issue_t issue_i,
    input  wire logic      stall_i,
    output      ex_stage_t stage_o
);

    ex_stage_t stage_d;
    ex_stage_t stage_q;
    logic      valid_q;

    // next stage contents from the issue word
    always_comb begin
        stage_d               = '0;
        stage_d.valid         = issue_valid_i;
        stage_d.cond          = issue_i.cond;
        stage_d.jump          = issue_i.jump;
        stage_d.link          = issue_i.link;
        stage_d.alu_op        = issue_i.alu_op;
        stage_d.operand_left  = issue_i.operand_left;
        stage_d.operand_right = issue_i.operand_right;
        stage_d.cmp_left      = issue_i.cmp_left;
        stage_d.cmp_right     = issue_i.cmp_right;
        stage_d.funct3        = issue_i.funct3;
        stage_d.pc            = issue_i.pc;
        // ins_size counts halfwords
        stage_d.pc_inc        = issue_i.pc + {{(XLEN-3){1'b0}}, issue_i.ins_size, 1'b0};
        stage_d.regs2_data    = issue_i.regs2_data;
        stage_d.regd_addr     = issue_i.regd_addr;
        // zone decode
        case (issue_i.zone)
            ZONE_REGFILE: stage_d.regd_wr = 1'b1;
            ZONE_LOADQ:   stage_d.lq_wr   = 1'b1;
            ZONE_STOREQ:  stage_d.sq_wr   = 1'b1;
            default: begin
            end
        endcase
    end

    always_ff @(posedge clk_i or negedge resetb_i) begin
        if (!resetb_i) begin
            valid_q <= 1'b0;
        end else if (!stall_i) begin
            valid_q <= issue_valid_i;
        end
    end

    // payload holds while stalled
    always_ff @(posedge clk_i) begin
        if (!stall_i) begin
            stage_q <= stage_d;
        end
    end

    always_comb begin
        stage_o       = stage_q;
        stage_o.valid = valid_q;
    end

    // an accepted instruction targets at most one destination
    a_one_zone: assert property (@(posedge clk_i) disable iff (!resetb_i)
        issue_valid_i && !stall_i |=> $onehot0({stage_o.lq_wr, stage_o.sq_wr, stage_o.regd_wr}))
        else $error("more than one write flag in the stage");

endmodule

`default_nettype wire

/* ex_lsq_credit.sv */
//--------------------------------------------------------------------------
// load/store queue credit counter
//--------------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module ex_lsq_credit import ex_pkg::*; (
    input  wire logic clk_i,
    input  wire logic resetb_i,
    input  wire logic take_i,
    input  wire logic credit_i,
    output      logic has_credit_o
);

    logic [CREDIT_W-1:0] count_q;

    // take and return in one cycle cancel out
    always_ff @(posedge clk_i or negedge resetb_i) begin
        if (!resetb_i) begin
            count_q <= CREDIT_W'(LSQ_DEPTH);
        end else if (take_i && !credit_i) begin
            count_q <= count_q - CREDIT_W'(1);
        end else if (credit_i && !take_i) begin
            count_q <= count_q + CREDIT_W'(1);
        end
    end

    assign has_credit_o = count_q != '0;

    a_no_underflow: assert property (@(posedge clk_i) disable iff (!resetb_i)
        take_i && !credit_i |-> count_q != '0)
        else $error("queue credit underflow");

    // queue returned more than it was given
    a_no_overflow: assert property (@(posedge clk_i) disable iff (!resetb_i)
        credit_i && !take_i |-> count_q < LSQ_DEPTH)
        else $error("queue credit above depth");

endmodule

`default_nettype wire

/* ex_pkg.sv */
//--------------------------------------------------------------------------
// execute stage shared definitions
// widths, encodings and the structs passed between the stage blocks
//--------------------------------------------------------------------------
`default_nettype none

package ex_pkg;

    localparam int unsigned XLEN       = 32;
    localparam int unsigned REG_ADDR_W = 5;
    localparam int unsigned SHAMT_W    = 5;
    localparam int unsigned LSQ_DEPTH  = 4;
    localparam int unsigned CREDIT_W   = 3;

    typedef logic [2:0] funct3_t;

    // access size on loads and stores
    localparam funct3_t F3_BYTE = 3'b000;
    localparam funct3_t F3_HALF = 3'b001;
    localparam funct3_t F3_WORD = 3'b010;

    // compare select on conditional instructions
    localparam funct3_t F3_BEQ  = 3'b000;
    localparam funct3_t F3_BNE  = 3'b001;
    localparam funct3_t F3_BLT  = 3'b100;
    localparam funct3_t F3_BGE  = 3'b101;
    localparam funct3_t F3_BLTU = 3'b110;
    localparam funct3_t F3_BGEU = 3'b111;

    typedef enum logic [3:0] {
        ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR,
        ALU_SLL, ALU_SRL, ALU_SRA, ALU_SLT, ALU_SLTU
    } alu_op_e;

    typedef enum logic [1:0] {
        ZONE_NONE, ZONE_REGFILE, ZONE_LOADQ, ZONE_STOREQ
    } zone_e;

    typedef enum logic [1:0] {
        EXCP_NONE, EXCP_MAIF, EXCP_MALA, EXCP_MASA
    } excp_cause_e;

    //--------------------------------------------------------------------------
    // stage structs
    //--------------------------------------------------------------------------
    typedef struct packed {
        alu_op_e                alu_op;
        logic [XLEN-1:0]        operand_left;
        logic [XLEN-1:0]        operand_right;
        logic [XLEN-1:0]        cmp_left;
        logic [XLEN-1:0]        cmp_right;
        funct3_t                funct3;
        zone_e                  zone;
        logic                   cond;
        logic                   jump;
        logic                   link;
        logic [XLEN-1:0]        pc;
        // size in halfwords
        logic [1:0]             ins_size;
        logic [XLEN-1:0]        regs2_data;
        logic [REG_ADDR_W-1:0]  regd_addr;
    } ex_issue_t;

    typedef struct packed {
        logic                   valid;
        logic                   lq_wr;
        logic                   sq_wr;
        logic                   regd_wr;
        logic                   cond;
        logic                   jump;
        logic                   link;
        alu_op_e                alu_op;
        logic [XLEN-1:0]        operand_left;
        logic [XLEN-1:0]        operand_right;
        logic [XLEN-1:0]        cmp_left;
        logic [XLEN-1:0]        cmp_right;
        funct3_t                funct3;
        logic [XLEN-1:0]        pc;
        logic [XLEN-1:0]        pc_inc;
        logic [XLEN-1:0]        regs2_data;
        logic [REG_ADDR_W-1:0]  regd_addr;
    } ex_stage_t;

    typedef struct packed {
        logic [XLEN-3:0]        word;
        logic [1:0]             offset;
    } ex_addr_t;

    // alu result, seen as data or as an address
    typedef union packed {
        logic [XLEN-1:0]        data;
        ex_addr_t               addr;
    } ex_result_u;

    typedef struct packed {
        logic                   wr;
        logic [REG_ADDR_W-1:0]  addr;
        logic [XLEN-1:0]        data;
    } ex_wb_t;

    typedef struct packed {
        logic                   lq_wr;
        logic                   sq_wr;
        funct3_t                funct3;
        logic [REG_ADDR_W-1:0]  regd_addr;
        logic [XLEN-1:0]        data;
        logic [XLEN-1:0]        addr;
    } ex_lsq_t;

    typedef struct packed {
        logic                   jump;
        logic [XLEN-1:0]        addr;
    } ex_redirect_t;

    typedef struct packed {
        excp_cause_e            cause;
        logic [XLEN-1:0]        pc;
    } ex_excp_t;

endpackage

`default_nettype wire

/* ex_stage_top.sv */
//--------------------------------------------------------------------------
// RV32 execute stage top level
// issue register, ALU, commit logic and load/store queue credits
//--------------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module ex_stage_top import ex_pkg::*; (
    input  wire logic         clk_i,
    input  wire logic         resetb_i,
    // decoder side
    input  wire logic         issue_valid_i,
    input  wire ex_issue_t    issue_i,
    output      logic         stall_o,
    // load/store queue credit return
    input  wire logic         lsq_credit_i,
    // results
    output      ex_wb_t       wb_o,
    output      ex_lsq_t      lsq_o,
    output      ex_redirect_t redirect_o,
    output      ex_excp_t     excp_o
);

    ex_stage_t  stage;
    ex_result_u result;
    logic       cmp;
    logic       take;
    logic       has_credit;

    ex_decode i_ex_decode (
        .clk_i         (clk_i),
        .resetb_i      (resetb_i),
        .issue_valid_i (issue_valid_i),
        .issue_i       (issue_i),
        .stall_i       (stall_o),
        .stage_o       (stage)
    );

    ex_alu i_ex_alu (
        .stage_i  (stage),
        .result_o (result),
        .cmp_o    (cmp)
    );

    ex_commit i_ex_commit (
        .stage_i      (stage),
        .result_i     (result),
        .cmp_i        (cmp),
        .has_credit_i (has_credit),
        .take_o       (take),
        .stall_o      (stall_o),
        .wb_o         (wb_o),
        .lsq_o        (lsq_o),
        .redirect_o   (redirect_o),
        .excp_o       (excp_o)
    );

    ex_lsq_credit i_ex_lsq_credit (
        .clk_i        (clk_i),
        .resetb_i     (resetb_i),
        .take_i       (take),
        .credit_i     (lsq_credit_i),
        .has_credit_o (has_credit)
    );

endmodule

`default_nettype wire

/* tb_clock_gen.sv */
//--------------------------------------------------------------------------
// testbench clock and reset
// 40 ns clock, active low reset held for three cycles
//--------------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen (
    output logic clk_o,
    output logic resetb_o
);

    localparam int HALF_PERIOD_NS = 20;
    localparam int RESET_CYCLES   = 3;

    initial begin
        clk_o = 1'b0;
        forever #(HALF_PERIOD_NS) clk_o = ~clk_o;
    end

    // release on a falling edge, away from the sampling edge
    initial begin
        resetb_o = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk_o);
        @(negedge clk_o);
        resetb_o = 1'b1;
    end

endmodule

`default_nettype wire

/* tb_ex_stage.sv */
//--------------------------------------------------------------------------
// execute stage testbench
// table of issue words and expected results, applied one row per cycle,
// with queue credit return and a watchdog
//--------------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module tb_ex_stage import ex_pkg::*; ();

    localparam int              CLK_PERIOD_NS = 40;
    localparam int              STALL_LIMIT   = 16;
    localparam logic [XLEN-1:0] SIGN_BIT      = 32'h8000_0000;

    typedef struct packed {
        ex_issue_t    issue;
        int unsigned  credit_delay;
        logic         give_credit;
        logic         stall;
        ex_wb_t       wb;
        ex_lsq_t      lsq;
        ex_redirect_t redirect;
        ex_excp_t     excp;
    } row_t;

    logic         clk_i;
    logic         resetb_i;
    logic         issue_valid_i;
    ex_issue_t    issue_i;
    logic         stall_o;
    logic         lsq_credit_i;
    ex_wb_t       wb_o;
    ex_lsq_t      lsq_o;
    ex_redirect_t redirect_o;
    ex_excp_t     excp_o;

    row_t            rows[$];
    logic [XLEN-1:0] rng_state;
    logic [XLEN-1:0] next_pc;
    int              credits_model;
    int              total_delay;
    bit              table_ready;

    tb_clock_gen i_tb_clock_gen (
        .clk_o    (clk_i),
        .resetb_o (resetb_i)
    );

    ex_stage_top i_ex_stage_top (
        .clk_i         (clk_i),
        .resetb_i      (resetb_i),
        .issue_valid_i (issue_valid_i),
        .issue_i       (issue_i),
        .stall_o       (stall_o),
        .lsq_credit_i  (lsq_credit_i),
        .wb_o          (wb_o),
        .lsq_o         (lsq_o),
        .redirect_o    (redirect_o),
        .excp_o        (excp_o)
    );

    //--------------------------------------------------------------------------
    // reference model
    //--------------------------------------------------------------------------
    function automatic logic [XLEN-1:0] xorshift32(input logic [XLEN-1:0] x);
        logic [XLEN-1:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic logic [XLEN-1:0] rand_word();
        rng_state = xorshift32(rng_state);
        return rng_state;
    endfunction

    function automatic logic [XLEN-1:0] model_alu(input alu_op_e op, input logic [XLEN-1:0] a,
                                                  input logic [XLEN-1:0] b);
        logic [4:0]      s;
        logic [XLEN-1:0] fill;
        s    = b[4:0];
        // sign bits shifted in from the left
        fill = a[XLEN-1] ? ~(32'hffff_ffff >> s) : 32'h0;
        case (op)
            ALU_ADD:  return a + b;
            ALU_SUB:  return a + ~b + 32'd1;
            ALU_AND:  return a & b;
            ALU_OR:   return a | b;
            ALU_XOR:  return a ^ b;
            ALU_SLL:  return a << s;
            ALU_SRL:  return a >> s;
            ALU_SRA:  return (a >> s) | fill;
            ALU_SLT:  return {31'd0, (a ^ SIGN_BIT) < (b ^ SIGN_BIT)};
            ALU_SLTU: return {31'd0, a < b};
            default:  return 32'h0;
        endcase
    endfunction

    function automatic logic model_cmp(input funct3_t f3, input logic [XLEN-1:0] a,
                                       input logic [XLEN-1:0] b);
        logic lt_s;
        logic lt_u;
        lt_u = a < b;
        lt_s = (a ^ SIGN_BIT) < (b ^ SIGN_BIT);
        case (f3)
            F3_BEQ:  return a == b;
            F3_BNE:  return a != b;
            F3_BLT:  return lt_s;
            F3_BGE:  return !lt_s;
            F3_BLTU: return lt_u;
            F3_BGEU: return !lt_u;
            default: return 1'b0;
        endcase
    endfunction

    //--------------------------------------------------------------------------
    // table construction
    //--------------------------------------------------------------------------
    function automatic row_t blank_row(input alu_op_e op, input logic [XLEN-1:0] left,
                                       input logic [XLEN-1:0] right, input zone_e zone,
                                       input logic [REG_ADDR_W-1:0] rd);
        row_t r;
        r                       = '0;
        r.issue.alu_op          = op;
        r.issue.operand_left    = left;
        r.issue.operand_right   = right;
        r.issue.zone            = zone;
        r.issue.regd_addr       = rd;
        r.issue.pc              = next_pc;
        // four byte instructions only
        r.issue.ins_size        = 2'd2;
        return r;
    endfunction

    task automatic push_row(input row_t r);
        rows.push_back(r);
        total_delay = total_delay + int'(r.credit_delay);
        next_pc     = next_pc + 32'd4;
    endtask

    task automatic alu_row(input alu_op_e op, input logic [REG_ADDR_W-1:0] rd);
        logic [XLEN-1:0] a;
        logic [XLEN-1:0] b;
        row_t            r;
        a         = rand_word();
        b         = rand_word();
        r         = blank_row(op, a, b, ZONE_REGFILE, rd);
        r.wb.wr   = 1'b1;
        r.wb.addr = rd;
        r.wb.data = model_alu(op, a, b);
        push_row(r);
    endtask

    // write back only when the compare holds
    task automatic compare_row(input funct3_t f3, input logic [XLEN-1:0] ca,
                               input logic [XLEN-1:0] cb, input logic [REG_ADDR_W-1:0] rd);
        logic [XLEN-1:0] a;
        logic [XLEN-1:0] b;
        row_t            r;
        a                 = rand_word();
        b                 = rand_word();
        r                 = blank_row(ALU_XOR, a, b, ZONE_REGFILE, rd);
        r.issue.cond      = 1'b1;
        r.issue.funct3    = f3;
        r.issue.cmp_left  = ca;
        r.issue.cmp_right = cb;
        r.wb.wr           = model_cmp(f3, ca, cb);
        r.wb.addr         = rd;
        r.wb.data         = model_alu(ALU_XOR, a, b);
        push_row(r);
    endtask

    task automatic branch_row(input funct3_t f3, input logic [XLEN-1:0] ca,
                              input logic [XLEN-1:0] cb, input logic [XLEN-1:0] offset);
        row_t r;
        r                 = blank_row(ALU_ADD, next_pc, offset, ZONE_NONE, 5'd0);
        r.issue.cond      = 1'b1;
        r.issue.jump      = 1'b1;
        r.issue.funct3    = f3;
        r.issue.cmp_left  = ca;
        r.issue.cmp_right = cb;
        r.redirect.jump   = model_cmp(f3, ca, cb);
        r.redirect.addr   = next_pc + offset;
        push_row(r);
    endtask

    task automatic jump_link_row(input logic [XLEN-1:0] offset,
                                 input logic [REG_ADDR_W-1:0] rd);
        row_t r;
        r               = blank_row(ALU_ADD, next_pc, offset, ZONE_REGFILE, rd);
        r.issue.jump    = 1'b1;
        r.issue.link    = 1'b1;
        r.wb.wr         = 1'b1;
        r.wb.addr       = rd;
        r.wb.data       = next_pc + 32'(r.issue.ins_size) * 32'd2;
        r.redirect.jump = 1'b1;
        r.redirect.addr = next_pc + offset;
        push_row(r);
    endtask

    task automatic mem_row(input logic store, input funct3_t f3, input logic [XLEN-1:0] offset,
                           input logic [REG_ADDR_W-1:0] rd, input logic ret,
                           input int unsigned delay);
        logic [XLEN-1:0] base;
        logic [XLEN-1:0] wdata;
        row_t            r;
        base                 = rand_word() & 32'hffff_fffc;
        wdata                = rand_word();
        r = blank_row(ALU_ADD, base, offset, store ? ZONE_STOREQ : ZONE_LOADQ, rd);
        r.issue.funct3       = f3;
        r.issue.regs2_data   = wdata;
        r.lsq.lq_wr          = !store;
        r.lsq.sq_wr          = store;
        r.lsq.funct3         = f3;
        r.lsq.regd_addr      = rd;
        r.lsq.data           = wdata;
        r.lsq.addr           = base + offset;
        // queue empty of credits means the row waits for a return
        if (credits_model == 0) begin
            r.stall        = 1'b1;
            r.credit_delay = delay;
        end else begin
            credits_model = credits_model - 1;
        end
        if (ret) begin
            r.give_credit = 1'b1;
            credits_model = credits_model + 1;
        end
        push_row(r);
    endtask

    task automatic misaligned_row(input zone_e zone, input funct3_t f3, input logic jump,
                                  input logic [XLEN-1:0] offset, input excp_cause_e cause);
        row_t r;
        r              = blank_row(ALU_ADD, rand_word() & 32'hffff_fffc, offset, zone, 5'd9);
        r.issue.funct3 = f3;
        r.issue.jump   = jump;
        r.issue.link   = jump;
        r.excp.cause   = cause;
        r.excp.pc      = r.issue.pc;
        push_row(r);
    endtask

    task automatic build_table();
        funct3_t         cmp_sel[6];
        logic [XLEN-1:0] a;
        logic [XLEN-1:0] b;
        cmp_sel = '{F3_BEQ, F3_BNE, F3_BLT, F3_BGE, F3_BLTU, F3_BGEU};
        for (int i = 0; i < 20; i++) begin
            alu_row(alu_op_e'(i % 10), REG_ADDR_W'(i + 1));
        end
        // swapped and equal pairs reach both outcomes of each compare
        foreach (cmp_sel[i]) begin
            a = rand_word();
            b = rand_word();
            compare_row(cmp_sel[i], a, b, 5'd3);
            compare_row(cmp_sel[i], b, a, 5'd4);
            compare_row(cmp_sel[i], a, a, 5'd5);
        end
        branch_row(F3_BNE, a, b, 32'h40);
        branch_row(F3_BEQ, a, b, 32'h80);
        jump_link_row(32'h100, 5'd1);
        jump_link_row(32'hffff_ff00, 5'd2);
        mem_row(1'b0, F3_WORD, 32'd8, 5'd10, 1'b1, 0);
        mem_row(1'b0, F3_HALF, 32'd2, 5'd11, 1'b1, 0);
        mem_row(1'b0, F3_BYTE, 32'd3, 5'd12, 1'b1, 0);
        mem_row(1'b1, F3_WORD, 32'd4, 5'd0, 1'b1, 0);
        mem_row(1'b1, F3_HALF, 32'd6, 5'd0, 1'b1, 0);
        misaligned_row(ZONE_LOADQ, F3_HALF, 1'b0, 32'd1, EXCP_MALA);
        misaligned_row(ZONE_STOREQ, F3_WORD, 1'b0, 32'd2, EXCP_MASA);
        misaligned_row(ZONE_REGFILE, F3_BYTE, 1'b1, 32'd6, EXCP_MAIF);
        // fifth store finds the queue out of credits
        for (int i = 0; i < 5; i++) begin
            mem_row(1'b1, F3_WORD, 32'(4 * i), 5'd0, 1'b0, 3);
        end
        alu_row(ALU_ADD, 5'd20);
        alu_row(ALU_SRA, 5'd21);
    endtask

    //--------------------------------------------------------------------------
    // checks
    //--------------------------------------------------------------------------
    task automatic abort_run(input string msg);
        $display("%s", msg);
        $display("Errors found");
        $fatal(1);
    endtask

    task automatic check_stall(input logic exp);
        if (stall_o !== exp) begin
            abort_run($sformatf("Mismatch at %0t: stall_o got %b expected %b",
                                $time, stall_o, exp));
        end
    endtask

    task automatic check_wb(input ex_wb_t got, input ex_wb_t exp);
        if (got.wr !== exp.wr || (exp.wr && (got.addr !== exp.addr || got.data !== exp.data))) begin
            abort_run($sformatf("Mismatch at %0t: wb_o got %h expected %h", $time, got, exp));
        end
    endtask

    task automatic check_lsq(input ex_lsq_t got, input ex_lsq_t exp);
        if (got.lq_wr !== exp.lq_wr || got.sq_wr !== exp.sq_wr ||
            ((exp.lq_wr || exp.sq_wr) && got !== exp)) begin
            abort_run($sformatf("Mismatch at %0t: lsq_o got %h expected %h", $time, got, exp));
        end
    endtask

    task automatic check_redirect(input ex_redirect_t got, input ex_redirect_t exp);
        if (got.jump !== exp.jump || (exp.jump && got.addr !== exp.addr)) begin
            abort_run($sformatf("Mismatch at %0t: redirect_o got %h expected %h",
                                $time, got, exp));
        end
    endtask

    task automatic check_excp(input ex_excp_t got, input ex_excp_t exp);
        if (got.cause !== exp.cause || (exp.cause != EXCP_NONE && got.pc !== exp.pc)) begin
            abort_run($sformatf("Mismatch at %0t: excp_o got %h expected %h", $time, got, exp));
        end
    endtask

    task automatic present_issue(input int idx);
        if (idx < rows.size()) begin
            issue_valid_i = 1'b1;
            issue_i       = rows[idx].issue;
        end else begin
            issue_valid_i = 1'b0;
            issue_i       = '0;
        end
    endtask

    //--------------------------------------------------------------------------
    // stimulus
    //--------------------------------------------------------------------------
    initial begin : main
        row_t r;
        int   wait_cycles;
        issue_valid_i = 1'b0;
        issue_i       = '0;
        lsq_credit_i  = 1'b0;
        rng_state     = 32'h92da_6d11;
        next_pc       = 32'h0000_1000;
        credits_model = LSQ_DEPTH;
        total_delay   = 0;
        build_table();
        table_ready = 1'b1;
        wait (resetb_i === 1'b1);
        @(negedge clk_i);
        present_issue(0);
        // row n sits in the stage at each pass, row n+1 waits at the input
        for (int n = 0; n < rows.size(); n++) begin
            r = rows[n];
            @(negedge clk_i);
            lsq_credit_i = 1'b0;
            present_issue(n + 1);
            if (r.stall) begin
                // held without credit, no queue strobe may leave the stage
                check_stall(1'b1);
                check_lsq(lsq_o, '0);
                repeat (r.credit_delay) begin
                    @(negedge clk_i);
                    check_stall(1'b1);
                    check_lsq(lsq_o, '0);
                end
                lsq_credit_i = 1'b1;
                @(negedge clk_i);
                lsq_credit_i = 1'b0;
                wait_cycles  = 0;
                while (stall_o === 1'b1) begin
                    if (wait_cycles >= STALL_LIMIT) begin
                        abort_run("stall_o stayed high after the credit return");
                    end
                    @(negedge clk_i);
                    wait_cycles = wait_cycles + 1;
                end
            end else begin
                check_stall(1'b0);
            end
            check_wb(wb_o, r.wb);
            check_lsq(lsq_o, r.lsq);
            check_redirect(redirect_o, r.redirect);
            check_excp(excp_o, r.excp);
            if (r.give_credit) begin
                lsq_credit_i = 1'b1;
            end
        end
        @(negedge clk_i);
        lsq_credit_i = 1'b0;
        $display("No errors");
        $finish;
    end

    initial begin : watchdog
        int limit_ns;
        wait (table_ready);
        limit_ns = (rows.size() + total_delay + 20) * CLK_PERIOD_NS;
        #(limit_ns);
        abort_run("watchdog expired before the table was done");
    end

endmodule

`default_nettype wire
